// ==== hw/mem_pkg.sv ====
package mem_pkg;

	// instruction class seen by the memory stage
	typedef enum logic [3:0] {
		OP_ALU = 4'd0,
		OP_LB  = 4'd1,
		OP_LH  = 4'd2,
		OP_LW  = 4'd3,
		OP_LBU = 4'd4,
		OP_LHU = 4'd5,
		OP_SB  = 4'd6,
		OP_SH  = 4'd7,
		OP_SW  = 4'd8
	} mem_op_t;

	typedef struct packed {
		mem_op_t     op;
		logic [4:0]  rd;
		logic        we;
		logic [31:0] alu_res;  // result or effective address
		logic [31:0] rt_data;  // store source
	} ex_mem_t;

	typedef struct packed {
		logic [4:0]  rd;
		logic        we;
		logic [31:0] wdata;
	} mem_wb_t;

	typedef struct packed {
		logic [31:0] addr;  // word aligned
		logic        wr;
		logic [3:0]  sel;   // byte lane enables
		logic [31:0] wdata;
	} ram_req_t;

	// one memory word, seen as bytes or as halfwords
	typedef union packed {
		logic [3:0][7:0]  b;
		logic [1:0][15:0] h;
	} mem_word_u;

endpackage

// ==== hw/ex_mem_reg.sv ====
`timescale 1ns/100ps

module ex_mem_reg import mem_pkg::*; (
	input  logic    clk,
	input  logic    rst,
	input  logic    in_valid_i,
	output logic    in_ready_o,
	input  ex_mem_t in_data_i,
	output logic    out_valid_o,
	input  logic    out_ready_i,
	output ex_mem_t out_data_o
);

	logic    valid_q;
	ex_mem_t data_q;

	// free when empty or being drained this cycle
	assign in_ready_o = !valid_q || out_ready_i;

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= 1'b0;
		end else if (in_valid_i && in_ready_o) begin
			valid_q <= 1'b1;
		end else if (out_ready_i) begin
			valid_q <= 1'b0;  // taken, nothing new
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid_i && in_ready_o) begin
			data_q <= in_data_i;
		end
	end

	assign out_valid_o = valid_q;
	assign out_data_o  = data_q;

endmodule

// ==== hw/load_align.sv ====
`timescale 1ns/100ps

module load_align import mem_pkg::*; (
	input  mem_op_t     op_i,
	input  logic [1:0]  ofs_i,
	input  logic [31:0] rdata_i,
	output logic [31:0] data_o
);

	mem_word_u   word;
	logic [7:0]  byte_sel;
	logic [15:0] half_sel;

	assign word     = rdata_i;
	assign byte_sel = word.b[ofs_i];
	assign half_sel = word.h[ofs_i[1]];

	always_comb begin
		data_o = '0;  // misaligned loads read zero
		case (op_i)
			OP_LB: begin
				data_o = {{24{byte_sel[7]}}, byte_sel};
			end
			OP_LBU: begin
				data_o = {24'b0, byte_sel};
			end
			OP_LH: begin
				if (!ofs_i[0]) begin
					data_o = {{16{half_sel[15]}}, half_sel};
				end
			end
			OP_LHU: begin
				if (!ofs_i[0]) begin
					data_o = {16'b0, half_sel};
				end
			end
			OP_LW: begin
				if (ofs_i == 2'b00) begin
					data_o = rdata_i;
				end
			end
			default: ;
		endcase
	end

endmodule

// ==== hw/data_ram.sv ====
`timescale 1ns/100ps

module data_ram import mem_pkg::*; #(
	parameter int WAIT_CYCLES = 2,
	parameter int DEPTH_WORDS = 256
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        req_valid_i,
	output logic        req_ready_o,
	input  ram_req_t    req_i,
	output logic        rsp_valid_o,
	output logic [31:0] rdata_o
);

	localparam int AW = $clog2(DEPTH_WORDS);
	localparam int CW = (WAIT_CYCLES > 1) ? $clog2(WAIT_CYCLES + 1) : 1;

	logic [3:0][7:0] mem [DEPTH_WORDS];
	ram_req_t        req_q;
	ram_req_t        cur_req;
	logic            busy_q;
	logic [CW-1:0]   cnt_q;
	logic            accept;
	logic            fire;
	logic [AW-1:0]   idx;
	logic [31:0]     rdata_q;

	assign req_ready_o = !busy_q;
	assign accept      = req_valid_i && !busy_q;
	// with no wait states the access happens on the accepting edge
	assign fire    = busy_q ? (cnt_q == CW'(1)) : (accept && WAIT_CYCLES == 0);
	assign cur_req = busy_q ? req_q : req_i;
	assign idx     = cur_req.addr[AW+1:2];

	always_ff @(posedge clk) begin
		if (rst) begin
			busy_q      <= 1'b0;
			rsp_valid_o <= 1'b0;
		end else begin
			rsp_valid_o <= fire;  // one cycle pulse
			if (accept && WAIT_CYCLES != 0) begin
				busy_q <= 1'b1;
			end else if (fire) begin
				busy_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			req_q <= req_i;
			cnt_q <= CW'(WAIT_CYCLES);
		end else if (busy_q) begin
			cnt_q <= cnt_q - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (fire) begin
			if (cur_req.wr) begin
				for (int i = 0; i < 4; i++) begin
					if (cur_req.sel[i]) begin
						mem[idx][i] <= cur_req.wdata[8*i +: 8];
					end
				end
			end else begin
				rdata_q <= mem[idx];
			end
		end
	end

	assign rdata_o = rdata_q;

endmodule

// ==== hw/mem_access.sv ====
`timescale 1ns/100ps

module mem_access import mem_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        in_valid_i,
	output logic        in_ready_o,
	input  ex_mem_t     in_data_i,
	output logic        ram_req_valid_o,
	input  logic        ram_req_ready_i,
	output ram_req_t    ram_req_o,
	input  logic        ram_rsp_valid_i,
	input  logic [31:0] ram_rdata_i,
	output mem_op_t     align_op_o,
	output logic [1:0]  align_ofs_o,
	input  logic [31:0] align_data_i,
	output logic        wb_valid_o,
	input  logic        wb_ready_i,
	output mem_wb_t     wb_data_o
);

	typedef enum logic [1:0] {ST_IDLE, ST_WAIT, ST_HOLD} state_t;

	state_t     state_q;
	mem_op_t    op_q;
	logic [1:0] ofs_q;
	mem_wb_t    wb_q;
	logic       is_load;
	logic       is_store;
	logic       accept;
	logic [3:0] sel;
	mem_word_u  st_word;

	assign is_load  = in_data_i.op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
	assign is_store = in_data_i.op inside {OP_SB, OP_SH, OP_SW};

	// ram is always idle here once we are back in ST_IDLE
	assign in_ready_o      = (state_q == ST_IDLE) && ram_req_ready_i;
	assign accept          = in_valid_i && in_ready_o;
	assign ram_req_valid_o = in_valid_i && (state_q == ST_IDLE) && (is_load || is_store);

	always_comb begin
		sel     = 4'b0000;
		st_word = in_data_i.rt_data;
		case (in_data_i.op)
			OP_SB: begin
				st_word.b = {4{in_data_i.rt_data[7:0]}};
				case (in_data_i.alu_res[1:0])
					2'b00:   sel = 4'b0001;
					2'b01:   sel = 4'b0010;
					2'b10:   sel = 4'b0100;
					default: sel = 4'b1000;
				endcase
			end
			OP_SH: begin
				st_word.h = {2{in_data_i.rt_data[15:0]}};
				case (in_data_i.alu_res[1:0])
					2'b00:   sel = 4'b0011;
					2'b10:   sel = 4'b1100;
					default: sel = 4'b0000;  // misaligned so no write
				endcase
			end
			OP_SW: begin
				sel = (in_data_i.alu_res[1:0] == 2'b00) ? 4'b1111 : 4'b0000;
			end
			default: ;
		endcase
	end

	always_comb begin
		ram_req_o.addr  = {in_data_i.alu_res[31:2], 2'b00};
		ram_req_o.wr    = is_store;
		ram_req_o.sel   = sel;
		ram_req_o.wdata = st_word;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= ST_IDLE;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (accept) begin
						state_q <= (is_load || is_store) ? ST_WAIT : ST_HOLD;
					end
				end
				ST_WAIT: begin
					if (ram_rsp_valid_i) begin
						state_q <= ST_HOLD;
					end
				end
				ST_HOLD: begin
					if (wb_ready_i) begin
						state_q <= ST_IDLE;
					end
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			op_q  <= in_data_i.op;
			ofs_q <= in_data_i.alu_res[1:0];
			wb_q  <= '{rd: in_data_i.rd, we: in_data_i.we, wdata: in_data_i.alu_res};
		end else if (state_q == ST_WAIT && ram_rsp_valid_i) begin
			if (op_q inside {OP_SB, OP_SH, OP_SW}) begin
				wb_q.we    <= 1'b0;  // stores write no register
				wb_q.wdata <= '0;
			end else begin
				wb_q.wdata <= align_data_i;
			end
		end
	end

	assign align_op_o  = op_q;
	assign align_ofs_o = ofs_q;
	assign wb_valid_o  = (state_q == ST_HOLD);
	assign wb_data_o   = wb_q;

endmodule

// ==== hw/mem_stage_top.sv ====
`timescale 1ns/100ps

module mem_stage_top import mem_pkg::*; #(
	parameter int WAIT_CYCLES = 2,
	parameter int DEPTH_WORDS = 256
) (
	input  logic    clk,
	input  logic    rst,
	input  logic    ex_valid_i,
	output logic    ex_ready_o,
	input  ex_mem_t ex_data_i,
	output logic    wb_valid_o,
	input  logic    wb_ready_i,
	output mem_wb_t wb_data_o
);

	logic        m_valid;
	logic        m_ready;
	ex_mem_t     m_data;
	logic        ram_req_valid;
	logic        ram_req_ready;
	ram_req_t    ram_req;
	logic        ram_rsp_valid;
	logic [31:0] ram_rdata;
	mem_op_t     align_op;
	logic [1:0]  align_ofs;
	logic [31:0] align_data;

	ex_mem_reg u_ex_mem_reg (
		.clk         (clk),
		.rst         (rst),
		.in_valid_i  (ex_valid_i),
		.in_ready_o  (ex_ready_o),
		.in_data_i   (ex_data_i),
		.out_valid_o (m_valid),
		.out_ready_i (m_ready),
		.out_data_o  (m_data)
	);

	mem_access u_mem_access (
		.clk             (clk),
		.rst             (rst),
		.in_valid_i      (m_valid),
		.in_ready_o      (m_ready),
		.in_data_i       (m_data),
		.ram_req_valid_o (ram_req_valid),
		.ram_req_ready_i (ram_req_ready),
		.ram_req_o       (ram_req),
		.ram_rsp_valid_i (ram_rsp_valid),
		.ram_rdata_i     (ram_rdata),
		.align_op_o      (align_op),
		.align_ofs_o     (align_ofs),
		.align_data_i    (align_data),
		.wb_valid_o      (wb_valid_o),
		.wb_ready_i      (wb_ready_i),
		.wb_data_o       (wb_data_o)
	);

	load_align u_load_align (
		.op_i    (align_op),
		.ofs_i   (align_ofs),
		.rdata_i (ram_rdata),
		.data_o  (align_data)
	);

	data_ram #(
		.WAIT_CYCLES (WAIT_CYCLES),
		.DEPTH_WORDS (DEPTH_WORDS)
	) u_data_ram (
		.clk         (clk),
		.rst         (rst),
		.req_valid_i (ram_req_valid),
		.req_ready_o (ram_req_ready),
		.req_i       (ram_req),
		.rsp_valid_o (ram_rsp_valid),
		.rdata_o     (ram_rdata)
	);

endmodule

// ==== tests/tb_vectors.svh ====
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

localparam int NUM_VEC = 29;

ex_mem_t stim_tab [NUM_VEC];
mem_wb_t exp_tab [NUM_VEC];
int      vec_n = 0;

// op, rd, we, alu_res, rt_data, then expected we and wdata
task automatic add_vec(input mem_op_t op, input logic [4:0] rd, input logic we,
	input logic [31:0] addr, input logic [31:0] data,
	input logic exp_we, input logic [31:0] exp_data);
	stim_tab[vec_n] = '{op: op, rd: rd, we: we, alu_res: addr, rt_data: data};
	exp_tab[vec_n]  = '{rd: rd, we: exp_we, wdata: exp_data};
	vec_n++;
endtask

task automatic fill_table();
	add_vec(OP_ALU, 5'd3,  1'b1, 32'h1234_5678, 32'h0,         1'b1, 32'h1234_5678);
	add_vec(OP_ALU, 5'd4,  1'b0, 32'hcafe_f00d, 32'h5555_5555, 1'b0, 32'hcafe_f00d);
	add_vec(OP_SW,  5'd7,  1'b1, 32'h10,        32'hdead_beef, 1'b0, 32'h0);  // we dropped
	add_vec(OP_LW,  5'd5,  1'b1, 32'h10,        32'h0,         1'b1, 32'hdead_beef);
	add_vec(OP_SB,  5'd0,  1'b0, 32'h20,        32'haaaa_aa11, 1'b0, 32'h0);
	add_vec(OP_SB,  5'd0,  1'b0, 32'h21,        32'hbbbb_bb22, 1'b0, 32'h0);
	add_vec(OP_SB,  5'd0,  1'b0, 32'h22,        32'hcccc_cc33, 1'b0, 32'h0);
	add_vec(OP_SB,  5'd0,  1'b0, 32'h23,        32'hdddd_dd84, 1'b0, 32'h0);
	add_vec(OP_LW,  5'd8,  1'b1, 32'h20,        32'h0,         1'b1, 32'h8433_2211);
	add_vec(OP_LB,  5'd9,  1'b1, 32'h23,        32'h0,         1'b1, 32'hffff_ff84);
	add_vec(OP_LBU, 5'd10, 1'b1, 32'h23,        32'h0,         1'b1, 32'h0000_0084);
	add_vec(OP_LB,  5'd11, 1'b1, 32'h21,        32'h0,         1'b1, 32'h0000_0022);
	add_vec(OP_LBU, 5'd12, 1'b1, 32'h22,        32'h0,         1'b1, 32'h0000_0033);
	add_vec(OP_SH,  5'd0,  1'b0, 32'h30,        32'h1234_8001, 1'b0, 32'h0);
	add_vec(OP_SH,  5'd0,  1'b0, 32'h32,        32'h5678_7ffe, 1'b0, 32'h0);
	add_vec(OP_LH,  5'd13, 1'b1, 32'h30,        32'h0,         1'b1, 32'hffff_8001);
	add_vec(OP_LHU, 5'd14, 1'b1, 32'h30,        32'h0,         1'b1, 32'h0000_8001);
	add_vec(OP_LH,  5'd15, 1'b1, 32'h32,        32'h0,         1'b1, 32'h0000_7ffe);
	add_vec(OP_LHU, 5'd16, 1'b1, 32'h32,        32'h0,         1'b1, 32'h0000_7ffe);
	add_vec(OP_LW,  5'd17, 1'b1, 32'h30,        32'h0,         1'b1, 32'h7ffe_8001);
	add_vec(OP_SW,  5'd0,  1'b0, 32'h40,        32'h0bad_f00d, 1'b0, 32'h0);
	add_vec(OP_SH,  5'd0,  1'b0, 32'h41,        32'hffff_ffff, 1'b0, 32'h0);  // misaligned
	add_vec(OP_SW,  5'd0,  1'b0, 32'h42,        32'h1111_1111, 1'b0, 32'h0);  // misaligned
	add_vec(OP_LW,  5'd18, 1'b1, 32'h40,        32'h0,         1'b1, 32'h0bad_f00d);
	add_vec(OP_LH,  5'd19, 1'b1, 32'h41,        32'h0,         1'b1, 32'h0);
	add_vec(OP_LW,  5'd20, 1'b1, 32'h42,        32'h0,         1'b1, 32'h0);
	add_vec(OP_LHU, 5'd21, 1'b1, 32'h43,        32'h0,         1'b1, 32'h0);
	add_vec(OP_ALU, 5'd31, 1'b1, 32'hffff_ffff, 32'h0,         1'b1, 32'hffff_ffff);
	add_vec(OP_LW,  5'd6,  1'b1, 32'h10,        32'h0,         1'b1, 32'hdead_beef);
endtask

`endif

// ==== tests/tb_mem_stage.sv ====
`timescale 1ns/100ps

module tb_mem_stage import mem_pkg::*; ();

	localparam int WAIT_CYCLES = 2;

	logic    clk = 1'b0;
	logic    rst;
	logic    ex_valid_i;
	logic    ex_ready_o;
	ex_mem_t ex_data_i;
	logic    wb_valid_o;
	logic    wb_ready_i;
	mem_wb_t wb_data_o;

	logic [31:0] rnd = 32'hff75237d;
	int          rcv_cnt = 0;
	int          cycle_cnt = 0;

	`include "tb_vectors.svh"

	localparam int CYCLE_LIMIT = NUM_VEC * (WAIT_CYCLES + 3) * 4 + 50;

	mem_stage_top #(
		.WAIT_CYCLES (WAIT_CYCLES)
	) u_dut (
		.clk        (clk),
		.rst        (rst),
		.ex_valid_i (ex_valid_i),
		.ex_ready_o (ex_ready_o),
		.ex_data_i  (ex_data_i),
		.wb_valid_o (wb_valid_o),
		.wb_ready_i (wb_ready_i),
		.wb_data_o  (wb_data_o)
	);

	always #20 clk = ~clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic check_wb(input mem_wb_t got, input mem_wb_t exp);
		if (got !== exp) begin
			$display("ERR %0t: result %0d got rd=%0d we=%0b wdata=%h", $time, rcv_cnt,
				got.rd, got.we, got.wdata);
			$display("ERR %0t: expected rd=%0d we=%0b wdata=%h", $time,
				exp.rd, exp.we, exp.wdata);
			$display("SOME TESTS FAILED");
			$fatal(1, "writeback mismatch");
		end
	endtask

	// called on a falling edge, returns on the falling edge after the transfer
	task automatic send_entry(input ex_mem_t item);
		logic took;
		ex_valid_i = 1'b1;
		ex_data_i  = item;
		took       = 1'b0;
		while (!took) begin
			took = ex_ready_o;  // holds through the next rising edge
			@(negedge clk);
		end
		ex_valid_i = 1'b0;
	endtask

	// random back-pressure, handshake predicted from values held to the next edge
	always @(negedge clk) begin
		rnd = xorshift32(rnd);
		wb_ready_i = (rnd[1:0] != 2'b00);
		if (wb_valid_o === 1'b1 && wb_ready_i) begin
			if (rcv_cnt >= NUM_VEC) begin
				$display("extra writeback record arrived after all %0d expected ones", NUM_VEC);
				$display("SOME TESTS FAILED");
				$fatal(1, "unexpected writeback");
			end else begin
				check_wb(wb_data_o, exp_tab[rcv_cnt]);
				rcv_cnt++;
			end
		end
	end

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("timeout after %0d cycles with %0d of %0d results received",
				cycle_cnt, rcv_cnt, NUM_VEC);
			$display("SOME TESTS FAILED");
			$fatal(1, "simulation timed out");
		end
	end

	initial begin
		rst        = 1'b1;
		ex_valid_i = 1'b0;
		ex_data_i  = '0;
		wb_ready_i = 1'b0;
		fill_table();
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		for (int i = 0; i < NUM_VEC; i++) begin
			send_entry(stim_tab[i]);  // back to back
		end
		wait (rcv_cnt == NUM_VEC);
		repeat (20) @(negedge clk);  // catch any stray extra result
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

// ==== project.f ====
+incdir+tests
hw/mem_pkg.sv
hw/ex_mem_reg.sv
hw/load_align.sv
hw/data_ram.sv
hw/mem_access.sv
hw/mem_stage_top.sv
tests/tb_mem_stage.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the memory stage testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f project.f --top-module tb_mem_stage
if [ $? -ne 0 ]; then
	echo "compile step failed"
	exit 1
fi

./obj_dir/Vtb_mem_stage > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "SOME TESTS FAILED" "$LOG"; then
	echo "simulation reported failure"
	exit 1
fi

if [ $sim_status -ne 0 ]; then
	echo "simulator exited with status $sim_status"
	exit 1
fi

echo "simulation finished cleanly"
exit 0
